//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = queue_system_tb
FILELIST  = build.f
PASS_MSG  = TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- build.f
+incdir+.
qs_pkg.sv
qs_ingress_classifier.sv
qs_port_queue.sv
qs_egress_scheduler.sv
qs_queue_system.sv
tb_clock_gen.sv
queue_system_tb.sv

//--- qs_egress_scheduler.sv
/* Round-robin egress scheduler, forwards one whole packet
   at a time with ready/valid back-pressure */

`timescale 1ns/100ps
`include "qs_macros.svh"

module qs_egress_scheduler (
    input  logic                        core_clk_ifc,
    input  logic                        rst_n,
    input  logic [`QS_NUM_PORTS-1:0]    pkt_avail,
    input  qs_pkg::word_t               head_data [`QS_NUM_PORTS],
    input  logic [`QS_NUM_PORTS-1:0]    head_last,
    output logic [`QS_NUM_PORTS-1:0]    rd,
    output logic                        out_valid,
    output qs_pkg::word_t               out_data,
    output qs_pkg::port_id_t            out_port,
    output logic                        out_last,
    input  logic                        out_ready
);

    localparam int ptr_w = $clog2(`QS_NUM_PORTS);

    qs_pkg::sched_state_t state;

    // Last served port, also the grant while a packet is in transfer
    logic [ptr_w-1:0]   last_ptr;
    logic [ptr_w-1:0]   next_idx;
    logic [ptr_w-1:0]   cand;
    logic               found;
    logic               accept;

    //////////////////////////////////////////////////
    // Round-robin search

    // Starts at the port after the last one served
    always_comb begin
        found    = 1'b0;
        next_idx = last_ptr;
        cand     = last_ptr;
        for (int k = 1; k <= `QS_NUM_PORTS; k++) begin
            cand = ptr_w'((int'(last_ptr) + k) % `QS_NUM_PORTS);
            if (!found && pkt_avail[cand]) begin
                found    = 1'b1;
                next_idx = cand;
            end
        end
    end

    //////////////////////////////////////////////////
    // Select / transfer FSM

    assign accept = out_valid && out_ready;

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            state    <= qs_pkg::SCHED_SELECT;
            last_ptr <= ptr_w'(`QS_NUM_PORTS - 1);
        end else begin
            case (state)
                qs_pkg::SCHED_SELECT: begin
                    if (found) begin
                        last_ptr <= next_idx;
                        state    <= qs_pkg::SCHED_TRANSFER;
                    end
                end
                qs_pkg::SCHED_TRANSFER: begin
                    if (accept && head_last[last_ptr]) begin
                        state <= qs_pkg::SCHED_SELECT;
                    end
                end
                default: state <= qs_pkg::SCHED_SELECT;
            endcase
        end
    end

    // Whole packet is stored, so the head is always valid in transfer
    assign out_valid = (state == qs_pkg::SCHED_TRANSFER);
    assign out_data  = head_data[last_ptr];
    assign out_last  = head_last[last_ptr];
    assign out_port  = qs_pkg::port_id_t'(last_ptr);

    always_comb begin
        rd           = '0;
        rd[last_ptr] = accept;
    end

endmodule

//--- qs_ingress_classifier.sv
/* Ingress classifier: steers each packet to its egress queue
   and discards packets with an invalid port */

`timescale 1ns/100ps
`include "qs_macros.svh"

module qs_ingress_classifier (
    input  logic                        core_clk_ifc,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  qs_pkg::word_t               in_data,
    input  qs_pkg::port_id_t            in_port,
    input  qs_pkg::wlen_t               in_wlen,
    input  logic                        in_last,
    output logic [`QS_NUM_PORTS-1:0]    q_wr,
    output qs_pkg::word_t               q_data,
    output logic                        q_first,
    output logic                        q_last,
    output qs_pkg::wlen_t               q_wlen,
    output logic                        bad_port_drop
);

    qs_pkg::cls_state_t state;
    logic               first_word;
    logic               port_ok;
    logic               fwd;

    //////////////////////////////////////////////////
    // Packet boundary tracking

    // Any valid word seen while idle opens a packet
    assign first_word = in_valid && (state == qs_pkg::CLS_IDLE);
    assign port_ok    = (in_port < qs_pkg::port_id_t'(`QS_NUM_PORTS));

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            state <= qs_pkg::CLS_IDLE;
        end else if (in_valid) begin
            if (in_last) begin
                state <= qs_pkg::CLS_IDLE;
            end else if (first_word) begin
                state <= port_ok ? qs_pkg::CLS_FORWARD : qs_pkg::CLS_DISCARD;
            end
        end
    end

    //////////////////////////////////////////////////
    // Steering

    // Decision comes from the port on the first word, from the state after that
    assign fwd = in_valid && (first_word ? port_ok : (state == qs_pkg::CLS_FORWARD));

    always_comb begin
        for (int i = 0; i < `QS_NUM_PORTS; i++) begin
            q_wr[i] = fwd && (in_port == qs_pkg::port_id_t'(i));
        end
    end

    // Payload fans out to every queue, only q_wr selects one
    assign q_data  = in_data;
    assign q_first = first_word;
    assign q_last  = in_last;
    assign q_wlen  = in_wlen;

    // One pulse per bad packet, on its first word
    assign bad_port_drop = first_word && !port_ok;

endmodule

//--- qs_macros.svh
/* Queue system sizing macros: port count, field widths,
   queue depth and packet length limit */

`ifndef QS_MACROS_SVH
`define QS_MACROS_SVH

// Number of egress queues
`define QS_NUM_PORTS 4

// Width of the egress port field, values 4 to 7 are invalid
`define QS_PORT_W 3

// Data word width in bits
`define QS_DATA_W 32

// Storage per queue, in words
`define QS_QUEUE_DEPTH 16

// Longest packet in words, shortest is one word
`define QS_MAX_PKT_WORDS 8

`endif

//--- qs_pkg.sv
/* Shared queue system types: data word, port id, packet length
   and the FSM state encodings */

`include "qs_macros.svh"

package qs_pkg;

    typedef logic [`QS_DATA_W-1:0] word_t;

    typedef logic [`QS_PORT_W-1:0] port_id_t;

    // Must hold the value QS_MAX_PKT_WORDS itself
    typedef logic [$clog2(`QS_MAX_PKT_WORDS + 1)-1:0] wlen_t;

    typedef enum logic [1:0] {
        CLS_IDLE,
        CLS_FORWARD,
        CLS_DISCARD
    } cls_state_t;

    typedef enum logic {
        SCHED_SELECT,
        SCHED_TRANSFER
    } sched_state_t;

endpackage

//--- qs_port_queue.sv
/* Per-port packet FIFO with whole-packet tail-drop admission
   and a count of complete stored packets */

`timescale 1ns/100ps
`include "qs_macros.svh"

module qs_port_queue (
    input  logic            core_clk_ifc,
    input  logic            rst_n,
    input  logic            wr,
    input  qs_pkg::word_t   wr_data,
    input  logic            wr_first,
    input  logic            wr_last,
    input  qs_pkg::wlen_t   wr_wlen,
    input  logic            rd,
    output qs_pkg::word_t   head_data,
    output logic            head_last,
    output logic            pkt_avail,
    output logic            drop
);

    localparam int addr_w = $clog2(`QS_QUEUE_DEPTH);
    localparam int cnt_w  = $clog2(`QS_QUEUE_DEPTH + 1);

    qs_pkg::word_t      mem_data [`QS_QUEUE_DEPTH];
    logic               mem_last [`QS_QUEUE_DEPTH];

    logic [addr_w-1:0]  wr_ptr;
    logic [addr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]   word_cnt;
    logic [cnt_w-1:0]   pkt_cnt;
    logic [cnt_w-1:0]   free_words;
    logic               fits;
    logic               admit_q;
    logic               accept;
    logic               wr_en;
    logic               rd_last;

    //////////////////////////////////////////////////
    // Admission

    assign free_words = cnt_w'(`QS_QUEUE_DEPTH) - word_cnt;
    assign fits       = (cnt_w'(wr_wlen) <= free_words);

    // First word decides, later words follow the stored decision
    assign accept = wr_first ? fits : admit_q;

    // Full check guards against a packet longer than its length field
    assign wr_en  = wr && accept && (word_cnt != cnt_w'(`QS_QUEUE_DEPTH));
    assign drop   = wr && wr_first && !fits;

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            admit_q <= 1'b0;
        end else if (wr && wr_first) begin
            admit_q <= fits;
        end
    end

    //////////////////////////////////////////////////
    // Storage

    always_ff @(posedge core_clk_ifc) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= wr_data;
            mem_last[wr_ptr] <= wr_last;
        end
    end

    assign head_data = mem_data[rd_ptr];
    assign head_last = mem_last[rd_ptr];
    assign rd_last   = rd && head_last;

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            word_cnt <= '0;
            pkt_cnt  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd})
                2'b10:   word_cnt <= word_cnt + 1'b1;
                2'b01:   word_cnt <= word_cnt - 1'b1;
                default: word_cnt <= word_cnt;
            endcase
            // Packet becomes visible once its last word is stored
            case ({wr_en && wr_last, rd_last})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;
            endcase
        end
    end

    assign pkt_avail = (pkt_cnt != '0);

endmodule

//--- qs_queue_system.sv
/* Egress queue system top: classifier, per-port queues
   and round-robin scheduler */

`timescale 1ns/100ps
`include "qs_macros.svh"

module qs_queue_system (
    input  logic                        core_clk_ifc,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  qs_pkg::word_t               in_data,
    input  qs_pkg::port_id_t            in_port,
    input  qs_pkg::wlen_t               in_wlen,
    input  logic                        in_last,
    output logic                        out_valid,
    output qs_pkg::word_t               out_data,
    output qs_pkg::port_id_t            out_port,
    output logic                        out_last,
    input  logic                        out_ready,
    output logic                        bad_port_drop,
    output logic [`QS_NUM_PORTS-1:0]    queue_drop
);

    logic [`QS_NUM_PORTS-1:0]   q_wr;
    qs_pkg::word_t              q_data;
    logic                       q_first;
    logic                       q_last;
    qs_pkg::wlen_t              q_wlen;

    logic [`QS_NUM_PORTS-1:0]   pkt_avail;
    qs_pkg::word_t              head_data [`QS_NUM_PORTS];
    logic [`QS_NUM_PORTS-1:0]   head_last;
    logic [`QS_NUM_PORTS-1:0]   rd;

    //////////////////////////////////////////////////
    // Ingress

    qs_ingress_classifier u_classifier (
        .core_clk_ifc   (core_clk_ifc),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .in_port        (in_port),
        .in_wlen        (in_wlen),
        .in_last        (in_last),
        .q_wr           (q_wr),
        .q_data         (q_data),
        .q_first        (q_first),
        .q_last         (q_last),
        .q_wlen         (q_wlen),
        .bad_port_drop  (bad_port_drop)
    );

    //////////////////////////////////////////////////
    // Per-port queues

    for (genvar g = 0; g < `QS_NUM_PORTS; g++) begin : g_queue
        qs_port_queue u_queue (
            .core_clk_ifc   (core_clk_ifc),
            .rst_n          (rst_n),
            .wr             (q_wr[g]),
            .wr_data        (q_data),
            .wr_first       (q_first),
            .wr_last        (q_last),
            .wr_wlen        (q_wlen),
            .rd             (rd[g]),
            .head_data      (head_data[g]),
            .head_last      (head_last[g]),
            .pkt_avail      (pkt_avail[g]),
            .drop           (queue_drop[g])
        );
    end

    //////////////////////////////////////////////////
    // Egress

    qs_egress_scheduler u_scheduler (
        .core_clk_ifc   (core_clk_ifc),
        .rst_n          (rst_n),
        .pkt_avail      (pkt_avail),
        .head_data      (head_data),
        .head_last      (head_last),
        .rd             (rd),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .out_port       (out_port),
        .out_last       (out_last),
        .out_ready      (out_ready)
    );

endmodule

//--- queue_system_tb.sv
/* Queue system testbench: packet stimulus, reference model,
   output checker and result reporting */

`timescale 1ns/100ps
`include "qs_macros.svh"

module queue_system_tb;

    localparam int n_ports        = `QS_NUM_PORTS;
    localparam int depth          = `QS_QUEUE_DEPTH;
    localparam int timeout_cycles = 2000;

    logic               core_clk_ifc;
    logic               rst_n;
    logic               in_valid;
    qs_pkg::word_t      in_data;
    qs_pkg::port_id_t   in_port;
    qs_pkg::wlen_t      in_wlen;
    logic               in_last;
    logic               out_valid;
    qs_pkg::word_t      out_data;
    qs_pkg::port_id_t   out_port;
    logic               out_last;
    logic               out_ready = 1'b0;
    logic               bad_port_drop;
    logic [n_ports-1:0] queue_drop;

    integer             seed = 77;
    logic               ready_level = 1'b1;
    logic               ready_random = 1'b0;
    logic               chk_seq = 1'b0;
    logic               in_pkt = 1'b0;
    int                 cur_port = 0;

    // Packet log written by the sender, consumed by the reference model
    int                 lg_port [$];
    int                 lg_len [$];
    qs_pkg::word_t      lg_data [$];
    int                 log_pos = 0;
    int                 data_pos = 0;

    qs_pkg::word_t      exp_data [n_ports][$];
    logic               exp_last [n_ports][$];
    int                 exp_seq [$];
    int                 adm_words [n_ports] = '{default: 0};
    int                 rx_words [n_ports] = '{default: 0};
    int                 exp_qdrop [n_ports] = '{default: 0};
    int                 rx_qdrop [n_ports] = '{default: 0};
    int                 exp_bad = 0;
    int                 rx_bad = 0;
    int                 err_cnt = 0;
    int                 chk_err = 0;
    int                 test_cnt = 0;
    int                 fail_cnt = 0;

    tb_clock_gen u_clk (
        .core_clk_ifc   (core_clk_ifc),
        .rst_n          (rst_n)
    );

    qs_queue_system dut0 (
        .core_clk_ifc   (core_clk_ifc),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .in_port        (in_port),
        .in_wlen        (in_wlen),
        .in_last        (in_last),
        .out_valid      (out_valid),
        .out_data       (out_data),
        .out_port       (out_port),
        .out_last       (out_last),
        .out_ready      (out_ready),
        .bad_port_drop  (bad_port_drop),
        .queue_drop     (queue_drop)
    );

    //////////////////////////////////////////////////
    // Stimulus helpers

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Gaps fall only between words so the call returns right after the last one
    task automatic send_pkt(input int port, input int len, input int gap_max);
        qs_pkg::word_t w;
        lg_port.push_back(port);
        lg_len.push_back(len);
        for (int i = 0; i < len; i++) begin
            if (i > 0 && gap_max > 0) begin
                in_valid = 1'b0;
                repeat (rand_range(0, gap_max)) @(negedge core_clk_ifc);
            end
            w = $random(seed);
            lg_data.push_back(w);
            in_valid = 1'b1;
            in_data  = w;
            in_port  = qs_pkg::port_id_t'(port);
            in_wlen  = qs_pkg::wlen_t'(len);
            in_last  = (i == len - 1);
            @(negedge core_clk_ifc);
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    always @(negedge core_clk_ifc) begin
        out_ready = ready_random ? 1'($random(seed)) : ready_level;
    end

    //////////////////////////////////////////////////
    // Reference model

    // Admission from the known occupancy; a held batch drains first packet
    // first, then in round-robin order from that port
    function automatic void predict_batch();
        int left [n_ports];
        int first_port;
        int n_adm;
        int port;
        int len;
        int ptr;
        int c;
        first_port = -1;
        n_adm = 0;
        c = 0;
        for (int p = 0; p < n_ports; p++) begin
            left[p] = 0;
        end
        exp_seq.delete();
        while (log_pos < lg_port.size()) begin
            port = lg_port[log_pos];
            len  = lg_len[log_pos];
            if (port >= n_ports) begin
                exp_bad++;
            end else if (len <= depth - (adm_words[port] - rx_words[port])) begin
                for (int i = 0; i < len; i++) begin
                    exp_data[port].push_back(lg_data[data_pos + i]);
                    exp_last[port].push_back(i == len - 1);
                end
                adm_words[port] += len;
                left[port]++;
                n_adm++;
                if (first_port < 0) begin
                    first_port = port;
                end
            end else begin
                exp_qdrop[port]++;
            end
            data_pos += len;
            log_pos++;
        end
        ptr = first_port;
        for (int n = 0; n < n_adm; n++) begin
            if (n > 0) begin
                for (int k = 1; k <= n_ports; k++) begin
                    c = (ptr + k) % n_ports;
                    if (left[c] > 0) break;
                end
                ptr = c;
            end
            exp_seq.push_back(ptr);
            left[ptr]--;
        end
    endfunction

    function automatic int words_pending();
        int sum;
        sum = 0;
        for (int p = 0; p < n_ports; p++) begin
            sum += exp_data[p].size();
        end
        return sum;
    endfunction

    //////////////////////////////////////////////////
    // Output comparison

    task automatic check_word();
        int  p;
        logic known;
        p = int'(out_port);
        known = (p < n_ports) ? (exp_data[p].size() > 0) : 1'b0;
        if (!in_pkt) begin
            cur_port = p;
            if (chk_seq && exp_seq.size() > 0) begin
                assert (p == exp_seq[0]) else begin
                    $display("Error: out_port 0x%h at packet start, expected 0x%h",
                             out_port, exp_seq[0]);
                    chk_err++;
                end
                void'(exp_seq.pop_front());
            end
        end else begin
            assert (p == cur_port) else begin
                $display("Error: out_port 0x%h inside a packet from port 0x%h",
                         out_port, cur_port);
                chk_err++;
            end
        end
        in_pkt = !out_last;
        assert (known) else begin
            $display("Unexpected output word 0x%h on port %0d", out_data, p);
            chk_err++;
        end
        if (known) begin
            assert (out_data == exp_data[p][0]) else begin
                $display("Error: out_data 0x%h, expected 0x%h", out_data, exp_data[p][0]);
                chk_err++;
            end
            assert (out_last == exp_last[p][0]) else begin
                $display("Error: out_last 0x%h, expected 0x%h", out_last, exp_last[p][0]);
                chk_err++;
            end
            void'(exp_data[p].pop_front());
            void'(exp_last[p].pop_front());
            rx_words[p]++;
        end
    endtask

    always @(posedge core_clk_ifc) begin
        if (rst_n) begin
            if (bad_port_drop) begin
                rx_bad++;
            end
            for (int p = 0; p < n_ports; p++) begin
                if (queue_drop[p]) begin
                    rx_qdrop[p]++;
                end
            end
            if (out_valid && out_ready) begin
                check_word();
            end
        end
    end

    //////////////////////////////////////////////////
    // Waits and per-test reporting

    task automatic wait_room(input int port, input int len);
        int cycles;
        cycles = 0;
        while (adm_words[port] - rx_words[port] + len > depth && cycles < timeout_cycles) begin
            @(negedge core_clk_ifc);
            cycles++;
        end
        if (adm_words[port] - rx_words[port] + len > depth) begin
            $display("Timeout: queue %0d never drained enough for the next packet", port);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input int num, input string name, input int errs_before);
        int cycles;
        int errs;
        cycles = 0;
        while (words_pending() > 0 && cycles < timeout_cycles) begin
            @(negedge core_clk_ifc);
            cycles++;
        end
        if (words_pending() > 0) begin
            $display("Timeout: %0d expected words never left the DUT", words_pending());
            err_cnt++;
            for (int p = 0; p < n_ports; p++) begin
                exp_data[p].delete();
                exp_last[p].delete();
            end
        end
        cycles = 0;
        while (out_valid && cycles < timeout_cycles) begin
            @(negedge core_clk_ifc);
            cycles++;
        end
        if (out_valid) begin
            $display("Timeout: out_valid stayed high after all packets were out");
            err_cnt++;
        end
        assert (rx_bad == exp_bad) else begin
            $display("Error: bad_port_drop count 0x%h, expected 0x%h", rx_bad, exp_bad);
            err_cnt++;
        end
        for (int p = 0; p < n_ports; p++) begin
            assert (rx_qdrop[p] == exp_qdrop[p]) else begin
                $display("Error: queue_drop[%0d] count 0x%h, expected 0x%h",
                         p, rx_qdrop[p], exp_qdrop[p]);
                err_cnt++;
            end
        end
        errs = err_cnt + chk_err - errs_before;
        test_cnt++;
        if (errs != 0) begin
            fail_cnt++;
        end
        $display("Test %0d, %s: %s, %0d errors", num, name,
                 (errs == 0) ? "pass" : "fail", errs);
    endtask

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        int cycles;
        int errs_before;
        int drops_before;
        int n;
        int port;
        int len;
        in_valid = 1'b0;
        in_data  = '0;
        in_port  = '0;
        in_wlen  = '0;
        in_last  = 1'b0;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 100) begin
            @(negedge core_clk_ifc);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            err_cnt++;
        end
        @(negedge core_clk_ifc);

        errs_before = err_cnt + chk_err;
        for (int p = 0; p < n_ports; p++) begin
            send_pkt(p, rand_range(1, 8), 1);
            predict_batch();
        end
        finish_test(1, "one packet per valid port", errs_before);

        errs_before = err_cnt + chk_err;
        for (int p = n_ports; p < 8; p++) begin
            send_pkt(p, rand_range(1, 8), 1);
            predict_batch();
        end
        send_pkt(rand_range(0, n_ports - 1), rand_range(1, 8), 0);
        predict_batch();
        finish_test(2, "invalid ports dropped", errs_before);

        // Output is held so the queue can only fill
        errs_before = err_cnt + chk_err;
        ready_level = 1'b0;
        @(negedge core_clk_ifc);
        drops_before = exp_qdrop[1];
        n = 0;
        while (exp_qdrop[1] < drops_before + 2 && n < 12) begin
            send_pkt(1, rand_range(3, 8), 0);
            predict_batch();
            n++;
        end
        ready_level = 1'b1;
        finish_test(3, "tail drop on port 1", errs_before);

        errs_before = err_cnt + chk_err;
        ready_level = 1'b0;
        @(negedge core_clk_ifc);
        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 3; i++) begin
                send_pkt((i == 0) ? 0 : i + 1, rand_range(1, 4), 0);
            end
        end
        predict_batch();
        chk_seq = 1'b1;
        ready_level = 1'b1;
        finish_test(4, "round robin over ports 0, 2, 3", errs_before);
        chk_seq = 1'b0;

        // Paced so that no queue can overflow
        errs_before = err_cnt + chk_err;
        ready_random = 1'b1;
        for (int i = 0; i < 24; i++) begin
            port = rand_range(0, n_ports - 1);
            len  = rand_range(1, 8);
            wait_room(port, len);
            send_pkt(port, len, 2);
            predict_batch();
        end
        ready_random = 1'b0;
        ready_level  = 1'b1;
        finish_test(5, "random traffic under back-pressure", errs_before);

        $display("Tests run %0d, failed %0d, errors %0d", test_cnt, fail_cnt,
                 err_cnt + chk_err);
        if (fail_cnt == 0 && err_cnt + chk_err == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb_clock_gen.sv
/* Testbench clock and reset source: 4 ns clock,
   reset held low for 10 cycles */

`timescale 1ns/100ps

module tb_clock_gen (
    output logic core_clk_ifc,
    output logic rst_n
);

    initial begin
        core_clk_ifc = 1'b0;
        forever #2 core_clk_ifc = ~core_clk_ifc;
    end

    // Release on a falling edge, clear of the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        rst_n = 1'b1;
    end

endmodule
